// ==== Bender.yml ====
package:
  name: symb_rate_divider

sources:
  # Design
  - files:
      - rtl/mmi_pkg.sv
      - rtl/symb_rate_pkg.sv
      - rtl/mmi_if.sv
      - rtl/symb_rate_regs.sv
      - rtl/stream_skid_buf.sv
      - rtl/sample_repeater.sv
      - rtl/symb_rate_divider_top.sv
  # Verification
  - target: simulation
    files:
      - verif/symb_rate_divider_sva.sv
      - verif/tb_symb_rate_divider.sv

// ==== build.f ====
rtl/mmi_pkg.sv
rtl/symb_rate_pkg.sv
rtl/mmi_if.sv
rtl/symb_rate_regs.sv
rtl/stream_skid_buf.sv
rtl/sample_repeater.sv
rtl/symb_rate_divider_top.sv
verif/symb_rate_divider_sva.sv
verif/tb_symb_rate_divider.sv

// ==== rtl/mmi_if.sv ====
// ####################################################################
// Memory-mapped register bus with separate write and read channels
// ####################################################################

`timescale 1ns/1ps

interface mmi_if;

    // Write channel, address and data in one beat
    logic [mmi_pkg::MMI_ADDR_NB-1:0] waddr;
    logic [mmi_pkg::MMI_DATA_NB-1:0] wdata;
    logic                            wvalid;
    logic                            wready;

    // Read address
    logic [mmi_pkg::MMI_ADDR_NB-1:0] raddr;
    logic                            arvalid;
    logic                            arready;

    // Read response, held until rready
    logic [mmi_pkg::MMI_DATA_NB-1:0] rdata;
    logic                            rvalid;
    logic                            rready;

    // Bus initiator side
    modport master (
        output waddr, wdata, wvalid,
        input  wready,
        output raddr, arvalid,
        input  arready,
        input  rdata, rvalid,
        output rready
    );

    // Register block side
    modport slave (
        input  waddr, wdata, wvalid,
        output wready,
        input  raddr, arvalid,
        output arready,
        output rdata, rvalid,
        input  rready
    );

endinterface

// ==== rtl/mmi_pkg.sv ====
// ####################################################################
// Register bus package for the TX symbol rate block
// Bus widths and the register map
// ####################################################################

package mmi_pkg;

    // Bus widths
    localparam int MMI_DATA_NB = 32;    // Register data width
    localparam int MMI_ADDR_NB = 8;     // Register address width

    // Register map
    // Symbol rate in Msps, read/write
    localparam logic [MMI_ADDR_NB-1:0] ADDR_SYMB_RATE     = 8'd0;
    // Active select code, read only
    localparam logic [MMI_ADDR_NB-1:0] ADDR_SYMB_RATE_SEL = 8'd1;

    // Address count, anything at or above is unmapped
    localparam int NUM_MMI_REGS = 2;

endpackage

// ==== rtl/sample_repeater.sv ====
// ####################################################################
// Zero-order-hold repeater, each sample sent divisor times
// First copy carries the symbol start flag
// ####################################################################

`timescale 1ns/1ps

module sample_repeater (
    input  logic                                        clk_mmi,
    input  logic                                        sresetn_mmi_interconnect,

    input  logic [symb_rate_pkg::SYMB_RATE_SEL_NB-1:0]  symb_rate_sel,

    input  logic                                        in_valid,
    output logic                                        in_ready,
    input  symb_rate_pkg::iq_sample_t                   in_sample,

    output logic                                        out_valid,
    input  logic                                        out_ready,
    output symb_rate_pkg::tx_beat_t                     out_beat
);

    // Largest divisor is 4, so 3 bits of count
    localparam int CNT_NB = 3;

    symb_rate_pkg::iq_sample_t  sample_q;   // Held sample
    logic                       first_q;    // Next beat is the first copy
    logic [CNT_NB-1:0]          beats_left; // Beats still to send, current one included
    logic [CNT_NB-1:0]          divisor;

    logic                       in_xfer;
    logic                       out_xfer;
    logic                       last_beat;

    // Divisor is 2 ** select
    always_comb begin
        case (symb_rate_sel)
            symb_rate_pkg::TX_SYMB_RATE_FULL:    divisor = 3'd1;
            symb_rate_pkg::TX_SYMB_RATE_HALF:    divisor = 3'd2;
            symb_rate_pkg::TX_SYMB_RATE_QUARTER: divisor = 3'd4;
            default:                             divisor = 3'd1; // Unused code runs at full rate
        endcase
    end

    assign out_xfer  = out_valid & out_ready;
    assign last_beat = (beats_left == 3'd1);

    // Take a new sample when idle or as the last copy leaves
    assign in_ready = ~out_valid | (out_ready & last_beat);
    assign in_xfer  = in_valid & in_ready;

    // Beat counter and output valid
    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi_interconnect) begin
            out_valid  <= 1'b0;
            beats_left <= '0;
        end else if (in_xfer) begin
            out_valid  <= 1'b1;
            beats_left <= divisor;      // Select sampled only here
        end else if (out_xfer) begin
            beats_left <= beats_left - 3'd1;
            if (last_beat) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Held sample and start flag
    always_ff @(posedge clk_mmi) begin
        if (in_xfer) begin
            sample_q <= in_sample;
            first_q  <= 1'b1;
        end else if (out_xfer) begin
            first_q  <= 1'b0;           // Later copies are plain repeats
        end
    end

    assign out_beat.iq         = sample_q;
    assign out_beat.symb_start = first_q;

endmodule

// ==== rtl/stream_skid_buf.sv ====
// ####################################################################
// Two-entry valid/ready skid buffer, registered on both sides
// ####################################################################

`timescale 1ns/1ps

module stream_skid_buf #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk_mmi,
    input  logic     sresetn_mmi_interconnect,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // in_ready low means the skid entry holds a beat
    payload_t skid_data;

    logic     out_free;                 // Output entry empty or draining this cycle
    logic     stall_in;                 // Input beat arriving while output is stuck

    assign out_free = ~out_valid | out_ready;
    assign stall_in = in_valid & in_ready & ~out_free;

    // Control state
    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi_interconnect) begin
            out_valid <= 1'b0;
            in_ready  <= 1'b1;
        end else begin
            if (out_free) begin
                if (!in_ready) begin
                    out_valid <= 1'b1;  // Skid entry moves to the output
                    in_ready  <= 1'b1;
                end else begin
                    out_valid <= in_valid;
                end
            end else if (stall_in) begin
                in_ready <= 1'b0;       // Both entries now full
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk_mmi) begin
        if (out_free) begin
            out_data <= in_ready ? in_data : skid_data;
        end
        if (stall_in) begin
            skid_data <= in_data;       // Extra beat caught after ready fell
        end
    end

endmodule

// ==== rtl/symb_rate_divider_top.sv ====
// ####################################################################
// TX symbol rate divider top with register control and ZOH datapath
// ####################################################################

`timescale 1ns/1ps

module symb_rate_divider_top #(
    parameter int SYMB_RATE_MSPS [0:symb_rate_pkg::NUM_TX_SYMB_RATES-1] = '{100, 50, 25},
    parameter logic [symb_rate_pkg::SYMB_RATE_SEL_NB-1:0] DEFAULT_SYMB_RATE_SEL =
        symb_rate_pkg::TX_SYMB_RATE_FULL
) (
    input  logic                                clk_mmi,
    input  logic                                sresetn_mmi_interconnect,

    // Register bus
    input  logic [mmi_pkg::MMI_ADDR_NB-1:0]     mmi_waddr,
    input  logic [mmi_pkg::MMI_DATA_NB-1:0]     mmi_wdata,
    input  logic                                mmi_wvalid,
    output logic                                mmi_wready,
    input  logic [mmi_pkg::MMI_ADDR_NB-1:0]     mmi_raddr,
    input  logic                                mmi_arvalid,
    output logic                                mmi_arready,
    output logic [mmi_pkg::MMI_DATA_NB-1:0]     mmi_rdata,
    output logic                                mmi_rvalid,
    input  logic                                mmi_rready,

    // Sample input from the modulator
    input  logic                                in_valid,
    output logic                                in_ready,
    input  symb_rate_pkg::iq_sample_t           in_sample,

    // Repeated samples toward the DAC
    output logic                                out_valid,
    input  logic                                out_ready,
    output symb_rate_pkg::iq_sample_t           out_sample,
    output logic                                out_symb_start
);

    mmi_if mmi_bus ();

    logic [symb_rate_pkg::SYMB_RATE_SEL_NB-1:0] symb_rate_sel;

    logic                       skid_valid;     // in_skid to repeater
    logic                       skid_ready;
    symb_rate_pkg::iq_sample_t  skid_sample;

    logic                       rep_valid;      // Repeater to out_skid
    logic                       rep_ready;
    symb_rate_pkg::tx_beat_t    rep_beat;

    symb_rate_pkg::tx_beat_t    out_beat;

    // Plain bus ports onto the master side
    assign mmi_bus.waddr   = mmi_waddr;
    assign mmi_bus.wdata   = mmi_wdata;
    assign mmi_bus.wvalid  = mmi_wvalid;
    assign mmi_bus.raddr   = mmi_raddr;
    assign mmi_bus.arvalid = mmi_arvalid;
    assign mmi_bus.rready  = mmi_rready;
    assign mmi_wready      = mmi_bus.wready;
    assign mmi_arready     = mmi_bus.arready;
    assign mmi_rdata       = mmi_bus.rdata;
    assign mmi_rvalid      = mmi_bus.rvalid;

    symb_rate_regs #(
        .SYMB_RATE_MSPS        (SYMB_RATE_MSPS),
        .DEFAULT_SYMB_RATE_SEL (DEFAULT_SYMB_RATE_SEL)
    ) regs0 (
        .clk_mmi                  (clk_mmi),
        .sresetn_mmi_interconnect (sresetn_mmi_interconnect),
        .mmi                      (mmi_bus.slave),
        .symb_rate_sel            (symb_rate_sel)
    );

    stream_skid_buf #(.payload_t(symb_rate_pkg::iq_sample_t)) in_skid (
        .clk_mmi                  (clk_mmi),
        .sresetn_mmi_interconnect (sresetn_mmi_interconnect),
        .in_valid                 (in_valid),
        .in_ready                 (in_ready),
        .in_data                  (in_sample),
        .out_valid                (skid_valid),
        .out_ready                (skid_ready),
        .out_data                 (skid_sample)
    );

    sample_repeater repeater0 (
        .clk_mmi                  (clk_mmi),
        .sresetn_mmi_interconnect (sresetn_mmi_interconnect),
        .symb_rate_sel            (symb_rate_sel),
        .in_valid                 (skid_valid),
        .in_ready                 (skid_ready),
        .in_sample                (skid_sample),
        .out_valid                (rep_valid),
        .out_ready                (rep_ready),
        .out_beat                 (rep_beat)
    );

    // Cuts the repeater's combinational ready path at the output
    stream_skid_buf #(.payload_t(symb_rate_pkg::tx_beat_t)) out_skid (
        .clk_mmi                  (clk_mmi),
        .sresetn_mmi_interconnect (sresetn_mmi_interconnect),
        .in_valid                 (rep_valid),
        .in_ready                 (rep_ready),
        .in_data                  (rep_beat),
        .out_valid                (out_valid),
        .out_ready                (out_ready),
        .out_data                 (out_beat)
    );

    assign out_sample     = out_beat.iq;
    assign out_symb_start = out_beat.symb_start;

endmodule

// ==== rtl/symb_rate_pkg.sv ====
// ####################################################################
// TX symbol rate package with select codes and IQ stream types
// ####################################################################

package symb_rate_pkg;

    // Selectable rates and select encoding
    localparam int NUM_TX_SYMB_RATES = 3;   // Full, half, quarter
    localparam int SYMB_RATE_SEL_NB  = 2;   // Select code width

    // Divisor is 2 ** select
    localparam logic [SYMB_RATE_SEL_NB-1:0] TX_SYMB_RATE_FULL    = 2'd0; // DAC rate / 1
    localparam logic [SYMB_RATE_SEL_NB-1:0] TX_SYMB_RATE_HALF    = 2'd1; // DAC rate / 2
    localparam logic [SYMB_RATE_SEL_NB-1:0] TX_SYMB_RATE_QUARTER = 2'd2; // DAC rate / 4

    // One I or Q component
    localparam int IQ_NB = 16;

    // Complex baseband sample, I in the upper half
    typedef struct packed {
        logic signed [IQ_NB-1:0] i;
        logic signed [IQ_NB-1:0] q;
    } iq_sample_t;

    // Repeated output beat
    typedef struct packed {
        iq_sample_t iq;             // Held sample
        logic       symb_start;     // First copy of the sample
    } tx_beat_t;

endpackage

// ==== rtl/symb_rate_regs.sv ====
// ####################################################################
// Symbol rate registers with Msps to select lookup and held bus reads
// ####################################################################

`timescale 1ns/1ps

module symb_rate_regs #(
    parameter int SYMB_RATE_MSPS [0:symb_rate_pkg::NUM_TX_SYMB_RATES-1] = '{100, 50, 25},
    parameter logic [symb_rate_pkg::SYMB_RATE_SEL_NB-1:0] DEFAULT_SYMB_RATE_SEL =
        symb_rate_pkg::TX_SYMB_RATE_FULL
) (
    input  logic                                         clk_mmi,
    input  logic                                         sresetn_mmi_interconnect,
    mmi_if.slave                                         mmi,
    output logic [symb_rate_pkg::SYMB_RATE_SEL_NB-1:0]   symb_rate_sel
);

    localparam int DATA_NB = mmi_pkg::MMI_DATA_NB;
    localparam int ADDR_NB = mmi_pkg::MMI_ADDR_NB;
    localparam int SEL_NB  = symb_rate_pkg::SYMB_RATE_SEL_NB;

    // Unmapped address boundary at bus width
    localparam logic [ADDR_NB-1:0] ADDR_LIMIT = ADDR_NB'(mmi_pkg::NUM_MMI_REGS);

    // Msps value to select code, default when no entry matches
    function automatic logic [SEL_NB-1:0] rate_to_sel(input logic [DATA_NB-1:0] msps);
        logic [SEL_NB-1:0] sel;
        sel = DEFAULT_SYMB_RATE_SEL;
        for (int idx = 0; idx < symb_rate_pkg::NUM_TX_SYMB_RATES; idx++) begin
            if (msps == DATA_NB'(SYMB_RATE_MSPS[idx])) begin
                sel = SEL_NB'(idx);     // Last match wins, entries are unique anyway
            end
        end
        return sel;
    endfunction

    logic [DATA_NB-1:0] rate_reg;       // Written symbol rate in Msps
    logic [SEL_NB-1:0]  sel_reg;        // Derived select, read only on the bus

    logic               wr_xfer;
    logic               rd_xfer;
    logic               rd_in_range;
    logic [DATA_NB-1:0] rd_word;

    // Writes always accepted outside reset
    assign mmi.wready = sresetn_mmi_interconnect;

    // New read accepted once the held response is gone or leaving
    assign mmi.arready = ~mmi.rvalid | mmi.rready;

    assign wr_xfer = mmi.wvalid & mmi.wready;
    assign rd_xfer = mmi.arvalid & mmi.arready;

    // Read mux
    assign rd_in_range = (mmi.raddr < ADDR_LIMIT);
    always_comb begin
        rd_word = '0;                   // Unmapped reads return zero
        if (rd_in_range) begin
            if (mmi.raddr == mmi_pkg::ADDR_SYMB_RATE_SEL) begin
                rd_word = DATA_NB'(sel_reg);
            end else begin
                rd_word = rate_reg;
            end
        end
    end

    // Rate and select registers
    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi_interconnect) begin
            rate_reg <= DATA_NB'(SYMB_RATE_MSPS[DEFAULT_SYMB_RATE_SEL]);
            sel_reg  <= DEFAULT_SYMB_RATE_SEL;
        end else begin
            // Only the rate address is writable
            if (wr_xfer && mmi.waddr == mmi_pkg::ADDR_SYMB_RATE) begin
                rate_reg <= mmi.wdata;
            end
            sel_reg <= rate_to_sel(rate_reg);   // Follows the stored rate one edge later
        end
    end

    // Read response valid
    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi_interconnect) begin
            mmi.rvalid <= 1'b0;
        end else if (rd_xfer) begin
            mmi.rvalid <= 1'b1;
        end else if (mmi.rready) begin
            mmi.rvalid <= 1'b0;         // Response taken
        end
    end

    // Read data, loaded only on a read transfer
    always_ff @(posedge clk_mmi) begin
        if (rd_xfer) begin
            mmi.rdata <= rd_word;
        end
    end

    assign symb_rate_sel = sel_reg;

endmodule

// ==== verif/symb_rate_divider_sva.sv ====
// ####################################################################
// Handshake assertions bound into the symbol rate divider top
// ####################################################################

`timescale 1ns/1ps

module symb_rate_divider_sva (
    input logic                            clk_mmi,
    input logic                            sresetn_mmi_interconnect,
    input logic                            mmi_rvalid,
    input logic                            mmi_rready,
    input logic [mmi_pkg::MMI_DATA_NB-1:0] mmi_rdata,
    input logic                            skid_valid,  // in_skid to repeater
    input logic                            rep_valid,   // Repeater to out_skid
    input logic                            out_valid,
    input logic                            out_ready,
    input symb_rate_pkg::iq_sample_t       out_sample,
    input logic                            out_symb_start
);

    // Read response held until taken
    a_rdata_hold: assert property (@(posedge clk_mmi) disable iff (!sresetn_mmi_interconnect)
        mmi_rvalid && !mmi_rready |=> mmi_rvalid && $stable(mmi_rdata))
        else $error("read response changed while rready was low");

    // Output beat held under back-pressure
    a_out_hold: assert property (@(posedge clk_mmi) disable iff (!sresetn_mmi_interconnect)
        out_valid && !out_ready |=> out_valid && $stable(out_sample) && $stable(out_symb_start))
        else $error("output beat changed while out_ready was low");

    // All valids low on the first cycle out of reset
    a_reset_quiet: assert property (@(posedge clk_mmi)
        $rose(sresetn_mmi_interconnect) |-> !mmi_rvalid && !skid_valid && !rep_valid && !out_valid)
        else $error("a valid was high in the cycle after reset");

endmodule

bind symb_rate_divider_top symb_rate_divider_sva sva0 (
    .clk_mmi                  (clk_mmi),
    .sresetn_mmi_interconnect (sresetn_mmi_interconnect),
    .mmi_rvalid               (mmi_rvalid),
    .mmi_rready               (mmi_rready),
    .mmi_rdata                (mmi_rdata),
    .skid_valid               (skid_valid),
    .rep_valid                (rep_valid),
    .out_valid                (out_valid),
    .out_ready                (out_ready),
    .out_sample               (out_sample),
    .out_symb_start           (out_symb_start)
);

// ==== verif/tb_symb_rate_divider.sv ====
// ####################################################################
// Testbench for the symbol rate divider, register and stream tables
// ####################################################################

`timescale 1ns/1ps

module tb_symb_rate_divider;

    localparam int CLK_PERIOD = 10;
    localparam int REG_N      = 21;
    localparam int STREAM_N   = 6;

    localparam logic [7:0]  A_RATE      = mmi_pkg::ADDR_SYMB_RATE;
    localparam logic [7:0]  A_SEL       = mmi_pkg::ADDR_SYMB_RATE_SEL;
    localparam logic [7:0]  A_BAD       = 8'd5;          // Above the register map
    localparam logic [31:0] SEL_FULL    = 32'(symb_rate_pkg::TX_SYMB_RATE_FULL);
    localparam logic [31:0] SEL_HALF    = 32'(symb_rate_pkg::TX_SYMB_RATE_HALF);
    localparam logic [31:0] SEL_QUARTER = 32'(symb_rate_pkg::TX_SYMB_RATE_QUARTER);

    typedef struct packed {
        logic        is_read;       // 1 read and compare, 0 write
        logic [7:0]  addr;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
    } reg_step_t;

    typedef struct packed {
        logic [1:0]  sel;           // Select under test
        logic [7:0]  n_samples;
        logic        bp;            // Random out_ready
    } stream_step_t;

    reg_step_t reg_tab [REG_N] = '{
        '{1'b1, A_RATE, 32'd0,   32'd100},      // Reset values
        '{1'b1, A_SEL,  32'd0,   SEL_FULL},
        '{1'b0, A_RATE, 32'd50,  32'd0},
        '{1'b1, A_RATE, 32'd0,   32'd50},
        '{1'b1, A_SEL,  32'd0,   SEL_HALF},
        '{1'b0, A_RATE, 32'd25,  32'd0},
        '{1'b1, A_RATE, 32'd0,   32'd25},
        '{1'b1, A_SEL,  32'd0,   SEL_QUARTER},
        '{1'b0, A_RATE, 32'd100, 32'd0},
        '{1'b1, A_RATE, 32'd0,   32'd100},
        '{1'b1, A_SEL,  32'd0,   SEL_FULL},
        '{1'b0, A_RATE, 32'd25,  32'd0},        // Leave FULL first
        '{1'b0, A_RATE, 32'd60,  32'd0},        // No matching rate
        '{1'b1, A_RATE, 32'd0,   32'd60},
        '{1'b1, A_SEL,  32'd0,   SEL_FULL},     // Back to default
        '{1'b0, A_SEL,  32'd2,   32'd0},        // Read-only register
        '{1'b1, A_SEL,  32'd0,   SEL_FULL},
        '{1'b1, A_BAD,  32'd0,   32'd0},        // Unmapped reads zero
        '{1'b0, A_BAD,  32'd77,  32'd0},
        '{1'b1, A_RATE, 32'd0,   32'd60},
        '{1'b1, A_SEL,  32'd0,   SEL_FULL}
    };

    stream_step_t stream_tab [STREAM_N] = '{
        '{symb_rate_pkg::TX_SYMB_RATE_FULL,    8'd16, 1'b0},
        '{symb_rate_pkg::TX_SYMB_RATE_HALF,    8'd12, 1'b0},
        '{symb_rate_pkg::TX_SYMB_RATE_QUARTER, 8'd10, 1'b0},
        '{symb_rate_pkg::TX_SYMB_RATE_FULL,    8'd16, 1'b1},
        '{symb_rate_pkg::TX_SYMB_RATE_HALF,    8'd12, 1'b1},
        '{symb_rate_pkg::TX_SYMB_RATE_QUARTER, 8'd10, 1'b1}
    };

    logic                            clk_mmi;
    logic                            sresetn_mmi_interconnect;
    logic [mmi_pkg::MMI_ADDR_NB-1:0] mmi_waddr;
    logic [mmi_pkg::MMI_DATA_NB-1:0] mmi_wdata;
    logic                            mmi_wvalid;
    logic                            mmi_wready;
    logic [mmi_pkg::MMI_ADDR_NB-1:0] mmi_raddr;
    logic                            mmi_arvalid;
    logic                            mmi_arready;
    logic [mmi_pkg::MMI_DATA_NB-1:0] mmi_rdata;
    logic                            mmi_rvalid;
    logic                            mmi_rready;
    logic                            in_valid;
    logic                            in_ready;
    symb_rate_pkg::iq_sample_t       in_sample;
    logic                            out_valid;
    logic                            out_ready;
    symb_rate_pkg::iq_sample_t       out_sample;
    logic                            out_symb_start;

    integer                          seed;
    symb_rate_pkg::tx_beat_t         exp_q [$];      // Scoreboard, oldest beat first
    int                              beats_expected;
    int                              beats_seen;

    symb_rate_divider_top dut0 (.*);

    always #(CLK_PERIOD / 2) clk_mmi = ~clk_mmi;

    // Every output transfer over the whole run, extra beats included
    always @(posedge clk_mmi) begin
        if (out_valid && out_ready) begin
            beats_seen++;
        end
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // Rates per select, full DAC rate is 100 Msps
    function automatic logic [31:0] msps_for_sel(input logic [1:0] sel);
        case (sel)
            symb_rate_pkg::TX_SYMB_RATE_HALF:    return 32'd50;
            symb_rate_pkg::TX_SYMB_RATE_QUARTER: return 32'd25;
            default:                             return 32'd100;
        endcase
    endfunction

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
        mmi_waddr  <= addr;
        mmi_wdata  <= data;
        mmi_wvalid <= 1'b1;
        do @(posedge clk_mmi); while (!mmi_wready);
        mmi_wvalid <= 1'b0;
        repeat (2) @(posedge clk_mmi);  // Select follows the rate one edge later
    endtask

    task automatic check_read(input logic [7:0] addr, input logic [31:0] exp_data);
        logic [31:0] got;
        mmi_raddr   <= addr;
        mmi_arvalid <= 1'b1;
        do @(posedge clk_mmi); while (!mmi_arready);
        mmi_arvalid <= 1'b0;
        repeat (2) @(posedge clk_mmi);  // Response must hold while rready low
        mmi_rready <= 1'b1;
        do @(posedge clk_mmi); while (!mmi_rvalid);
        got = mmi_rdata;
        mmi_rready <= 1'b0;
        assert (got == exp_data)
        else abort_run($sformatf("MISMATCH at %0t: read addr %0d got %0d expected %0d",
                                 $time, addr, got, exp_data));
    endtask

    task automatic send_samples(input symb_rate_pkg::iq_sample_t samples [$]);
        foreach (samples[k]) begin
            in_valid  <= 1'b1;
            in_sample <= samples[k];
            do @(posedge clk_mmi); while (!in_ready);
        end
        in_valid <= 1'b0;
    endtask

    task automatic collect_beats(input logic bp);
        logic [31:0]             r;
        symb_rate_pkg::tx_beat_t exp_beat;
        while (exp_q.size() > 0) begin
            r = $random(seed);
            out_ready <= bp ? r[0] : 1'b1;
            @(posedge clk_mmi);
            if (out_valid && out_ready) begin
                exp_beat = exp_q.pop_front();
                assert (out_sample == exp_beat.iq && out_symb_start == exp_beat.symb_start)
                else abort_run($sformatf("MISMATCH at %0t: beat got %h/%b expected %h/%b",
                                         $time, out_sample, out_symb_start,
                                         exp_beat.iq, exp_beat.symb_start));
            end
        end
        out_ready <= 1'b1;
    endtask

    task automatic run_stream(input stream_step_t st);
        symb_rate_pkg::iq_sample_t samples [$];
        symb_rate_pkg::iq_sample_t s;
        symb_rate_pkg::tx_beat_t   beat;
        for (int k = 0; k < int'(st.n_samples); k++) begin
            s = $random(seed);
            samples.push_back(s);
            for (int c = 0; c < (1 << st.sel); c++) begin   // ZOH copies
                beat.iq         = s;
                beat.symb_start = (c == 0);
                exp_q.push_back(beat);
                beats_expected++;
            end
        end
        fork
            send_samples(samples);
            collect_beats(st.bp);
        join
        repeat (6) begin            // Nothing extra after the last copy
            @(posedge clk_mmi);
            assert (!out_valid) else abort_run("Output beat seen after the stream had ended");
        end
    endtask

    initial begin : watchdog
        int budget;                 // Cycles for the whole run
        budget = REG_N * 12;
        foreach (stream_tab[k]) begin
            budget += (int'(stream_tab[k].n_samples) << stream_tab[k].sel) + 40;
        end
        #(budget * 4 * CLK_PERIOD);
        abort_run("Timeout: the DUT stopped responding before the tables finished");
    end

    initial begin
        seed                     = 32'hf16e;
        beats_expected           = 0;
        beats_seen               = 0;
        clk_mmi                  = 1'b0;
        sresetn_mmi_interconnect = 1'b0;
        mmi_waddr                = '0;
        mmi_wdata                = '0;
        mmi_wvalid               = 1'b0;
        mmi_raddr                = '0;
        mmi_arvalid              = 1'b0;
        mmi_rready               = 1'b0;
        in_valid                 = 1'b0;
        in_sample                = '0;
        out_ready                = 1'b0;
        repeat (2) @(posedge clk_mmi);
        sresetn_mmi_interconnect <= 1'b1;

        foreach (reg_tab[k]) begin
            if (reg_tab[k].is_read) check_read(reg_tab[k].addr, reg_tab[k].exp_rdata);
            else bus_write(reg_tab[k].addr, reg_tab[k].wdata);
        end

        // Rate changes only while the stream is idle
        foreach (stream_tab[k]) begin
            bus_write(A_RATE, msps_for_sel(stream_tab[k].sel));
            check_read(A_SEL, 32'(stream_tab[k].sel));
            run_stream(stream_tab[k]);
        end

        if (beats_seen == beats_expected) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Beat count wrong, %0d seen of %0d", beats_seen, beats_expected);
            $display("Test FAILED");
            $fatal(1, "beat count check failed");
        end
    end

endmodule
